// File: source/smc_regs_pkg.sv
`default_nettype none

package smc_regs_pkg;

  // -------------------------------------------------------------------------
  // APB side widths
  // -------------------------------------------------------------------------
  localparam int APB_ADDR_W = 5;   // Byte address as seen on paddr
  localparam int APB_DATA_W = 32;
  localparam int WAIT_W     = 4;
  localparam int COUNT_W    = 16;  // Completed access counter

  typedef logic [APB_ADDR_W-1:0] apb_addr_t;
  typedef logic [APB_DATA_W-1:0] apb_data_t;
  typedef logic [WAIT_W-1:0]     wait_t;          // Extra strobe cycles
  typedef logic [COUNT_W-1:0]    access_count_t;

  // Register map
  localparam apb_addr_t ADDR_CONFIG = 5'h00;
  localparam apb_addr_t ADDR_STATUS = 5'h04;

  // Config image in bits 7:0 of register 0
  typedef struct packed {
    wait_t wr_wait;  // Bits 7:4
    wait_t rd_wait;  // Bits 3:0
  } smc_cfg_t;

  // Status image, read only
  typedef struct packed {
    logic [APB_DATA_W-COUNT_W-2:0] rsvd;  // Bits 31:17 read as zero
    logic                          busy;  // Bit 16
    access_count_t                 access_count;
  } smc_status_t;

  localparam smc_cfg_t CFG_RESET = '{wr_wait: 4'd2, rd_wait: 4'd3};

endpackage

`default_nettype wire

// File: source/smc_mem_pkg.sv
`default_nettype none

package smc_mem_pkg;

  // -------------------------------------------------------------------------
  // Memory side widths
  // -------------------------------------------------------------------------
  localparam int MEM_ADDR_W = 16;  // Word address
  localparam int MEM_DATA_W = 16;

  typedef logic [MEM_ADDR_W-1:0] mem_addr_t;
  typedef logic [MEM_DATA_W-1:0] mem_data_t;

  // One host request, sampled with the req strobe
  typedef struct packed {
    logic      write;  // 1 = write, 0 = read
    mem_addr_t addr;
    mem_data_t wdata;
  } host_req_t;

  // Pins toward the SRAM
  typedef struct packed {
    logic      cs_n;   // Chip select
    logic      oe_n;   // Output enable for reads
    logic      we_n;   // Write enable
    mem_addr_t addr;
    mem_data_t wdata;
  } mem_pins_t;

  // Access sequencer states
  typedef enum logic [1:0] {IDLE, SETUP, STROBE, HOLD} access_state_t;

endpackage

`default_nettype wire

// File: source/smc_apb_lite_if.sv
`timescale 1ns/10ps
`default_nettype none

// APB lite slave front end
// Address decode into register selects plus the read mux
module smc_apb_lite_if (
  input  wire                       psel,     // APB select
  input  wire                       penable,  // Access phase
  input  wire smc_regs_pkg::apb_addr_t   paddr,
  input  wire smc_regs_pkg::smc_cfg_t    cfg,     // Config register image
  input  wire smc_regs_pkg::smc_status_t status,  // Status register image
  output logic                      sel_config,
  output smc_regs_pkg::apb_data_t   prdata
);

  import smc_regs_pkg::*;

  localparam int CFG_PAD_W = APB_DATA_W - $bits(smc_cfg_t);  // Zero fill above cfg

  // -------------------------------------------------------------------------
  // Register select
  // -------------------------------------------------------------------------
  // Bit significant select, one per writable register
  always_comb
  begin : p_addr_decode
    if (psel && penable)
    begin
      if (paddr == ADDR_CONFIG)
        sel_config = 1'b1;
      else
        sel_config = 1'b0;  // Status and holes take no write
    end
    else
    begin
      sel_config = 1'b0;
    end
  end

  // -------------------------------------------------------------------------
  // Read data
  // -------------------------------------------------------------------------
  // Straight from paddr
  // No select needed for reads
  always_comb
  begin : p_read_mux
    case (paddr)
      ADDR_CONFIG:
        prdata = {{CFG_PAD_W{1'b0}}, cfg};  // Wait fields in 7:0
      ADDR_STATUS:
        prdata = status;  // Busy and access count
      default:
        prdata = '0;      // Unmapped
    endcase
  end

endmodule

`default_nettype wire

// File: source/smc_cfreg_lite.sv
`timescale 1ns/10ps
`default_nettype none

// Wait-state configuration register
module smc_cfreg_lite (
  input  wire                      pclk,
  input  wire                      reset,       // Sync, active high
  input  wire                      sel_config,  // From the address decode
  input  wire                      pwrite,
  input  wire smc_regs_pkg::apb_data_t  pwdata,
  output smc_regs_pkg::smc_cfg_t   cfg
);

  import smc_regs_pkg::*;

  localparam int CFG_W = $bits(smc_cfg_t);  // 8 bits of fields

  logic     cfg_wr;     // Write strobe for this register
  smc_cfg_t cfg_next;

  // Only the access phase of a write
  assign cfg_wr = sel_config && pwrite;

  // Low byte of pwdata maps straight onto the struct
  assign cfg_next = smc_cfg_t'(pwdata[CFG_W-1:0]);

  // -------------------------------------------------------------------------
  // Register
  // -------------------------------------------------------------------------
  always_ff @(posedge pclk)
  begin : p_cfg_reg
    if (reset)
    begin
      cfg <= CFG_RESET;  // rd_wait 3, wr_wait 2
    end
    else if (cfg_wr)
    begin
      cfg <= cfg_next;   // Visible on prdata next cycle
    end
  end

endmodule

`default_nettype wire

// File: source/smc_access_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

// Single access sequencer for one asynchronous SRAM chip select
module smc_access_ctrl (
  input  wire                           pclk,
  input  wire                           reset,      // Sync, active high
  input  wire                           req,        // One cycle start strobe
  input  wire smc_mem_pkg::host_req_t   req_info,
  input  wire smc_regs_pkg::smc_cfg_t   cfg,
  input  wire smc_mem_pkg::mem_data_t   mem_rdata,  // From the SRAM
  output smc_mem_pkg::mem_pins_t        mem_pins,
  output logic                          busy,
  output logic                          done,
  output smc_mem_pkg::mem_data_t        rdata,
  output smc_regs_pkg::smc_status_t     status
);

  import smc_regs_pkg::*;
  import smc_mem_pkg::*;

  access_state_t state_q;
  access_state_t state_d;
  logic          start;           // Accepted request
  logic          strobe_end;      // Last STROBE cycle
  wait_t         wait_cnt_q;      // STROBE cycles left minus one
  logic          write_q;         // Direction of the access in flight
  logic          cs_n_q;
  logic          oe_n_q;
  logic          we_n_q;
  mem_addr_t     addr_q;
  mem_data_t     wdata_q;
  mem_data_t     rdata_q;
  access_count_t access_count_q;

  assign start      = req && (state_q == IDLE);  // Ignored while busy
  assign strobe_end = (state_q == STROBE) && (wait_cnt_q == '0);

  // -------------------------------------------------------------------------
  // Next state
  // -------------------------------------------------------------------------
  always_comb
  begin : p_next_state
    state_d = state_q;
    case (state_q)
      IDLE:
      begin
        if (req)
          state_d = SETUP;
      end
      SETUP:
        state_d = STROBE;  // Always one cycle
      STROBE:
      begin
        if (wait_cnt_q == '0)
          state_d = HOLD;
      end
      HOLD:
        state_d = IDLE;
      default:
        state_d = IDLE;
    endcase
  end

  // -------------------------------------------------------------------------
  // State and pin control
  // -------------------------------------------------------------------------
  always_ff @(posedge pclk)
  begin : p_ctrl
    if (reset)
    begin
      state_q        <= IDLE;
      cs_n_q         <= 1'b1;
      oe_n_q         <= 1'b1;
      we_n_q         <= 1'b1;
      access_count_q <= '0;
    end
    else
    begin
      state_q <= state_d;
      if (start)
        cs_n_q <= 1'b0;  // Low from SETUP on
      if (state_q == SETUP)
      begin
        oe_n_q <= write_q;   // Read strobe
        we_n_q <= !write_q;  // Write strobe
      end
      if (strobe_end)
      begin
        oe_n_q <= 1'b1;
        we_n_q <= 1'b1;
      end
      if (state_q == HOLD)
      begin
        cs_n_q         <= 1'b1;
        access_count_q <= access_count_q + 1'b1;  // Wraps at 16 bits
      end
    end
  end

  // Request latch, wait count and read capture
  always_ff @(posedge pclk)
  begin : p_payload
    if (start)
    begin
      write_q    <= req_info.write;
      addr_q     <= req_info.addr;
      wdata_q    <= req_info.wdata;
      wait_cnt_q <= req_info.write ? cfg.wr_wait : cfg.rd_wait;  // Held for the access
    end
    else if ((state_q == STROBE) && (wait_cnt_q != '0))
    begin
      wait_cnt_q <= wait_cnt_q - 1'b1;
    end
    if (strobe_end && !write_q)
      rdata_q <= mem_rdata;  // Sampled on the last strobe edge
  end

  // -------------------------------------------------------------------------
  // Outputs
  // -------------------------------------------------------------------------
  assign mem_pins = '{cs_n: cs_n_q, oe_n: oe_n_q, we_n: we_n_q,
                      addr: addr_q, wdata: wdata_q};

  assign busy  = (state_q != IDLE);
  assign done  = (state_q == HOLD);  // One cycle pulse
  assign rdata = rdata_q;

  assign status = '{rsvd: '0, busy: busy, access_count: access_count_q};

endmodule

`default_nettype wire

// File: source/smc_lite_top.sv
`timescale 1ns/10ps
`default_nettype none

// Static memory controller with APB configuration port
module smc_lite_top (
  input  wire                           pclk,
  input  wire                           reset,
  // APB slave
  input  wire                           psel,
  input  wire                           penable,
  input  wire                           pwrite,
  input  wire smc_regs_pkg::apb_addr_t  paddr,
  input  wire smc_regs_pkg::apb_data_t  pwdata,
  output smc_regs_pkg::apb_data_t       prdata,
  // Host access port
  input  wire                           req,
  input  wire smc_mem_pkg::host_req_t   req_info,
  output logic                          busy,
  output logic                          done,
  output smc_mem_pkg::mem_data_t        rdata,
  // SRAM pins
  output smc_mem_pkg::mem_pins_t        mem_pins,
  input  wire smc_mem_pkg::mem_data_t   mem_rdata
);

  import smc_regs_pkg::*;

  logic        sel_config;  // Config register write select
  smc_cfg_t    cfg;         // Wait-state settings
  smc_status_t status;      // Busy and access count

  // APB decode and read mux
  smc_apb_lite_if u_apb_if (
    .psel       (psel),
    .penable    (penable),
    .paddr      (paddr),
    .cfg        (cfg),
    .status     (status),
    .sel_config (sel_config),
    .prdata     (prdata)
  );

  smc_cfreg_lite u_cfreg (
    .pclk       (pclk),
    .reset      (reset),
    .sel_config (sel_config),
    .pwrite     (pwrite),
    .pwdata     (pwdata),
    .cfg        (cfg)
  );

  // Memory access sequencer
  smc_access_ctrl u_access_ctrl (
    .pclk      (pclk),
    .reset     (reset),
    .req       (req),
    .req_info  (req_info),
    .cfg       (cfg),
    .mem_rdata (mem_rdata),
    .mem_pins  (mem_pins),
    .busy      (busy),
    .done      (done),
    .rdata     (rdata),
    .status    (status)
  );

endmodule

`default_nettype wire

// File: sim/smc_clk_gen.sv
`timescale 1ns/10ps
`default_nettype none

// Clock and reset source for the testbench
module smc_clk_gen (
  output logic pclk,
  output logic reset
);

  localparam int HALF_PERIOD  = 50;  // 100 ns clock
  localparam int RESET_CYCLES = 4;

  initial
  begin
    pclk = 1'b0;
    forever
      #HALF_PERIOD pclk = ~pclk;
  end

  initial
  begin
    reset = 1'b1;
    repeat (RESET_CYCLES)
      @(posedge pclk);
    reset <= 1'b0;  // Released on a rising edge
  end

endmodule

`default_nettype wire

// File: sim/smc_lite_sva.sv
`timescale 1ns/10ps
`default_nettype none

// Memory pin protocol checks on the access sequencer
module smc_lite_sva (
  input wire                         pclk,
  input wire                         reset,
  input wire smc_mem_pkg::mem_pins_t mem_pins,
  input wire                         done
);

  // --------------------------------------------------------------------------
  // Strobe rules
  // --------------------------------------------------------------------------
  a_strobe_excl: assert property (@(posedge pclk) disable iff (reset)
    !(!mem_pins.oe_n && !mem_pins.we_n))
    else $error("oe_n and we_n low in the same cycle");

  // Strobe only inside chip select
  a_strobe_in_cs: assert property (@(posedge pclk) disable iff (reset)
    (!mem_pins.oe_n || !mem_pins.we_n) |-> !mem_pins.cs_n)
    else $error("Strobe low while cs_n high");

  a_done_pulse: assert property (@(posedge pclk) disable iff (reset)
    done |=> !done)  // Single cycle
    else $error("done high for more than one cycle");

  // First cycle out of reset
  a_reset_idle: assert property (@(posedge pclk)
    $fell(reset) |-> (mem_pins.cs_n && mem_pins.oe_n && mem_pins.we_n && !done))
    else $error("Memory pins active right after reset");

endmodule

bind smc_access_ctrl smc_lite_sva u_sva (
  .pclk     (pclk),
  .reset    (reset),
  .mem_pins (mem_pins),
  .done     (done)
);

`default_nettype wire

// File: sim/smc_lite_tb.sv
`timescale 1ns/10ps
`default_nettype none

module smc_lite_tb;

  import smc_regs_pkg::*;
  import smc_mem_pkg::*;

  localparam int DONE_TIMEOUT = 40;  // Cycles for one access

  logic      pclk;
  logic      reset;
  logic      psel;
  logic      penable;
  logic      pwrite;
  apb_addr_t paddr;
  apb_data_t pwdata;
  apb_data_t prdata;
  logic      req;
  host_req_t req_info;
  logic      busy;
  logic      done;
  mem_data_t rdata;
  mem_pins_t mem_pins;
  mem_data_t mem_rdata;
  mem_data_t sram [0:63];  // 64 word SRAM model
  logic      sram_we_n;
  logic      load_stb;     // Preload strobe
  logic [5:0] load_addr;
  mem_data_t load_data;
  integer    seed;
  int        errors;
  int        tests;
  int        failed;
  int        test_err0;    // Error count at test start
  int        accepted;     // Requests the DUT should take

  smc_clk_gen u_clk_gen (.pclk(pclk), .reset(reset));

  smc_lite_top DUT (
    .pclk(pclk), .reset(reset), .psel(psel), .penable(penable),
    .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
    .req(req), .req_info(req_info), .busy(busy), .done(done), .rdata(rdata),
    .mem_pins(mem_pins), .mem_rdata(mem_rdata)
  );

  // --------------------------------------------------------------------------
  // SRAM model
  // --------------------------------------------------------------------------
  assign sram_we_n = mem_pins.we_n;
  assign mem_rdata = (!mem_pins.cs_n && !mem_pins.oe_n) ? sram[mem_pins.addr[5:0]] : '0;

  always @(posedge sram_we_n or posedge load_stb)
  begin : p_sram_write
    if (load_stb)
      sram[load_addr] = load_data;
    else if (!mem_pins.cs_n)
      sram[mem_pins.addr[5:0]] = mem_pins.wdata;  // Stored on rising we_n
  end

  task automatic check_value(input string name, input apb_data_t exp, input apb_data_t act);
    assert (act == exp)
    else
    begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors != test_err0)
      failed++;
    $display("Test %s: %s", name, (errors == test_err0) ? "pass" : "FAIL");
    test_err0 = errors;
  endtask

  task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
    @(posedge pclk);
    psel    <= 1'b1;  // Setup phase
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge pclk);
    penable <= 1'b1;
    @(posedge pclk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_read(input apb_addr_t addr, output apb_data_t data);
    @(posedge pclk);
    psel    <= 1'b1;
    paddr   <= addr;
    @(posedge pclk);
    penable <= 1'b1;
    @(negedge pclk);
    data = prdata;    // Mid access phase
    @(posedge pclk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic preload(input logic [5:0] addr, input mem_data_t data);
    @(negedge pclk);
    load_addr = addr;
    load_data = data;
    load_stb  = 1'b1;
    #1 load_stb = 1'b0;
  endtask

  task automatic start_req(input logic write, input mem_addr_t addr, input mem_data_t wdata);
    @(posedge pclk);
    req      <= 1'b1;
    req_info <= '{write: write, addr: addr, wdata: wdata};
    @(posedge pclk);
    req      <= 1'b0;  // One cycle strobe
  endtask

  // Counts from the edge that drove req
  task automatic wait_done(output int cycles);
    cycles = 1;
    @(negedge pclk);
    while (!done && cycles <= DONE_TIMEOUT)
    begin
      cycles++;
      @(negedge pclk);
    end
    if (!done)
    begin
      $display("Timeout: no done pulse within %0d cycles", DONE_TIMEOUT);
      errors++;
    end
  endtask

  task automatic host_access(input logic write, input mem_addr_t addr,
                             input mem_data_t wdata, output int cycles);
    start_req(write, addr, wdata);
    wait_done(cycles);
    accepted++;
  endtask

  // --------------------------------------------------------------------------
  // Tests
  // --------------------------------------------------------------------------
  initial
  begin : p_main
    apb_data_t rd;
    apb_data_t wd;
    apb_data_t cfg_exp;
    wait_t     rw;
    mem_addr_t a;
    mem_addr_t a2;
    mem_data_t d;
    mem_data_t d2;
    mem_data_t old2;
    int        cycles;
    int        n;
    int        extra_done;
    seed = 87;
    errors = 0;
    tests = 0;
    failed = 0;
    test_err0 = 0;
    accepted = 0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    req = 1'b0;
    req_info = '0;
    load_stb = 1'b0;
    load_addr = '0;
    load_data = '0;
    n = 0;
    @(negedge pclk);
    while (reset && n < 20)
    begin
      n++;
      @(negedge pclk);
    end
    if (reset)
    begin
      $display("Reset was never released");
      errors++;
    end

    // Reset values, wr_wait 2 and rd_wait 3
    apb_read(ADDR_CONFIG, rd);
    check_value("reset config", {24'h0, 4'd2, 4'd3}, rd);
    apb_read(ADDR_STATUS, rd);
    check_value("reset status", 32'h0, rd);
    end_test("reset_values");

    wd = $random(seed);
    cfg_exp = wd & 32'h0000_00ff;  // 8 bits kept
    apb_write(ADDR_CONFIG, wd);
    apb_read(ADDR_CONFIG, rd);
    check_value("config readback", cfg_exp, rd);
    wd = $random(seed);
    apb_write(ADDR_STATUS, wd);
    apb_read(ADDR_STATUS, rd);
    check_value("status write ignored", 32'h0, rd);
    apb_read(ADDR_CONFIG, rd);
    check_value("config after status write", cfg_exp, rd);
    apb_read(5'h08, rd);
    check_value("unmapped read", 32'h0, rd);
    end_test("register_map");

    for (int i = 0; i < 2; i++)
    begin
      rw = (i == 0) ? 4'd0 : 4'd6;
      apb_write(ADDR_CONFIG, {24'h0, 4'd2, rw});
      a = mem_addr_t'($random(seed) & 32'h3f);
      d = mem_data_t'($random(seed));
      preload(a[5:0], d);
      host_access(1'b0, a, 16'h0, cycles);
      check_value("read data", d, rdata);
      check_value("read latency", rw + 3, cycles);
    end
    end_test("read_access");

    apb_write(ADDR_CONFIG, {24'h0, 4'd4, 4'd3});  // wr_wait 4
    a2 = mem_addr_t'($random(seed) & 32'h3f);
    d2 = mem_data_t'($random(seed));
    host_access(1'b1, a2, d2, cycles);
    check_value("write data", d2, sram[a2[5:0]]);
    check_value("write latency", 32'd7, cycles);
    host_access(1'b0, a2, 16'h0, cycles);
    check_value("write readback", d2, rdata);
    end_test("write_access");

    // Second req lands in STROBE and must be dropped
    a = mem_addr_t'($random(seed) & 32'h3f);
    a2 = {a[15:6], a[5:0] ^ 6'h01};
    d = mem_data_t'($random(seed));
    d2 = mem_data_t'($random(seed));
    old2 = ~d2;
    preload(a2[5:0], old2);
    start_req(1'b1, a, d);
    accepted++;
    @(negedge pclk);
    check_value("busy at second req", 32'h1, {31'h0, busy});
    start_req(1'b1, a2, d2);
    wait_done(cycles);
    extra_done = 0;
    for (int k = 0; k < 12; k++)
    begin
      @(negedge pclk);
      if (done)
        extra_done++;
    end
    check_value("extra done pulses", 32'h0, extra_done);
    check_value("accepted write", d, sram[a[5:0]]);
    check_value("dropped write", old2, sram[a2[5:0]]);
    apb_read(ADDR_STATUS, rd);
    check_value("access count", accepted, rd);  // Busy low by now
    end_test("busy_rule");

    $display("Tests: %0d, failed: %0d, errors: %0d", tests, failed, errors);
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
source/smc_regs_pkg.sv
source/smc_mem_pkg.sv
source/smc_apb_lite_if.sv
source/smc_cfreg_lite.sv
source/smc_access_ctrl.sv
source/smc_lite_top.sv
sim/smc_clk_gen.sv
sim/smc_lite_sva.sv
sim/smc_lite_tb.sv

// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check $(LOG)"
	@echo "make clean  remove the build folder and $(LOG)"

test:
	verilator --binary --timing --assert --timescale 1ns/10ps -f vlog.f \
		--top-module smc_lite_tb -Mdir obj_dir -o smc_lite_sim
	./obj_dir/smc_lite_sim 2>&1 | tee $(LOG)
	@if grep -q -E "Done: errors found|%Error" $(LOG); then \
		echo "TEST FAILED"; exit 1; fi
	@if ! grep -q "Done: no errors" $(LOG); then \
		echo "TEST FAILED: run did not complete"; exit 1; fi
	@echo "TEST PASSED"

clean:
	rm -rf obj_dir $(LOG)
